/* logic/game_pkg.sv */
`default_nettype none

package game_pkg;

	////////////////////
	// keypad and lanes
	////////////////////
	localparam int KEY_W = 4; //keypad key code width

	localparam logic [15:0] LANE_LFSR_TAPS = 16'hb400; //galois feedback mask
	localparam logic [15:0] LANE_LFSR_SEED = 16'hace1; //lfsr state out of reset

	////////////////////
	// score limits
	////////////////////
	localparam int SCORE_MAX = 999; //three bcd digits
	localparam int MISS_MAX = 255; //one byte of misses

	////////////////////
	// host registers
	////////////////////
	localparam logic [1:0] REG_CTRL = 2'd0; //lane enables and round start
	localparam logic [1:0] REG_SCORE = 2'd1; //bcd score, write clears
	localparam logic [1:0] REG_MISS = 2'd2; //miss count
	localparam logic [1:0] REG_PEER = 2'd3; //peer fields, write sends dialogue

endpackage

`default_nettype wire

/* logic/link_pkg.sv */
`default_nettype none

package link_pkg;

	localparam int LINK_W = 9; //word between the two boards

	// kind bit values
	localparam logic LINK_KIND_DLG = 1'b0; //dialogue code word
	localparam logic LINK_KIND_SCORE = 1'b1; //score byte word

	// one link word read as dialogue or as score
	typedef union packed {
		struct packed {
			logic kind; //bit 8
			logic [3:0] code; //dialogue code
			logic [3:0] unused; //sent as zero
		} dlg;
		struct packed {
			logic kind; //bit 8
			logic [7:0] payload; //tens and units bcd
		} score;
	} link_word_u;

endpackage

`default_nettype wire

/* logic/round_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module round_dispatch #(
	parameter int N_LANES = 4 //number of game lanes
) (
	input wire clk, //system clock
	input wire rst, //sync reset
	input wire [game_pkg::KEY_W-1:0] key, //key code from keypad
	input wire pressed, //keypad press level
	input wire [N_LANES-1:0] lane_en, //lanes in the next round
	input wire round_start, //start pulse from host regs
	output logic load, //load strobe to every lane
	output logic [N_LANES*game_pkg::KEY_W-1:0] targets, //lane targets side by side
	output logic [N_LANES-1:0] arm, //arm bit per lane
	output logic key_evt, //one cycle per press
	output logic [game_pkg::KEY_W-1:0] key_code //key that goes with key_evt
);

	localparam int KW = game_pkg::KEY_W;

	logic [15:0] lfsr_q; //target lfsr, kept across rounds
	logic [15:0] step [N_LANES+1]; //states after each unrolled step
	logic press_q; //press sampled
	logic press_qq; //press one cycle back
	logic [KW-1:0] key_q; //key sampled with press_q

	////////////////////
	// target lfsr
	////////////////////
	always_comb begin
		step[0] = lfsr_q; //state before this round
		for (int i = 0; i < N_LANES; i++) begin
			step[i+1] = {1'b0, step[i][15:1]}
				^ (step[i][0] ? game_pkg::LANE_LFSR_TAPS : 16'h0000); //galois shift
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr_q <= game_pkg::LANE_LFSR_SEED;
			load <= 1'b0;
			arm <= '0;
			press_q <= 1'b0;
			press_qq <= 1'b0;
			key_evt <= 1'b0;
		end else begin
			load <= round_start; //lanes load one cycle after start
			if (round_start) begin
				lfsr_q <= step[N_LANES]; //advance by one step per lane
				arm <= lane_en; //mask as it stands at start
			end
			press_q <= pressed;
			press_qq <= press_q;
			key_evt <= press_q & ~press_qq; //rising edge of press
		end
	end

	////////////////////
	// payload
	////////////////////
	always_ff @(posedge clk) begin
		key_q <= key;
		key_code <= key_q; //lines up with key_evt
		if (round_start) begin
			for (int i = 0; i < N_LANES; i++) begin
				targets[i*KW +: KW] <= step[i+1][KW-1:0]; //low bits after step i+1
			end
		end
	end

endmodule

`default_nettype wire

/* logic/game_lane.sv */
`timescale 1ns/1ns
`default_nettype none

module game_lane (
	input wire clk, //system clock
	input wire rst, //sync reset
	input wire load, //take a new target
	input wire arm, //lane plays this round
	input wire [game_pkg::KEY_W-1:0] target, //target offered at load
	input wire key_evt, //press event
	input wire [game_pkg::KEY_W-1:0] key_code, //key of the press
	output logic hit, //right key pulse
	output logic miss //wrong key pulse
);

	logic armed; //waiting for a press
	logic [game_pkg::KEY_W-1:0] target_q; //held target
	logic live; //armed once any load this cycle is seen
	logic [game_pkg::KEY_W-1:0] want; //target once any load is seen
	logic grade; //this press gets graded

	// a press in the load cycle is graded against the new target
	assign live = load ? arm : armed;
	assign want = load ? target : target_q;
	assign grade = key_evt & live;

	always_ff @(posedge clk) begin
		if (rst) begin
			armed <= 1'b0;
			hit <= 1'b0;
			miss <= 1'b0;
		end else begin
			hit <= grade & (key_code == want);
			miss <= grade & (key_code != want);
			if (grade)
				armed <= 1'b0; //one grade per round
			else if (load)
				armed <= arm;
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			target_q <= target;
	end

endmodule

`default_nettype wire

/* logic/score_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module score_regs #(
	parameter int N_LANES = 4 //number of game lanes
) (
	input wire clk, //system clock
	input wire rst, //sync reset
	input wire [N_LANES-1:0] lane_hit, //hit pulses from lanes
	input wire [N_LANES-1:0] lane_miss, //miss pulses from lanes
	input wire wb_cyc, //wishbone cycle
	input wire wb_stb, //wishbone strobe
	input wire wb_we, //wishbone write
	input wire [1:0] wb_adr, //register address
	input wire [15:0] wb_dat_w, //write data
	output logic [15:0] wb_dat_r, //read data, valid with ack
	output logic wb_ack, //one cycle ack
	output logic [N_LANES-1:0] lane_en, //lane enable mask
	output logic round_start, //pulse in the ack cycle
	input wire [link_pkg::LINK_W-1:0] link_in, //word from peer
	input wire link_in_valid, //peer word strobe
	output logic [link_pkg::LINK_W-1:0] link_out, //word to peer
	output logic link_out_valid //outgoing word strobe
);

	localparam int CNT_W = $clog2(N_LANES + 1);

	logic [CNT_W-1:0] hit_cnt, miss_cnt; //results this cycle
	logic [11:0] score_q; //bcd hundreds tens units
	logic [11:0] score_nx;
	logic [9:0] score_bin; //binary score plus hits
	logic [9:0] score_sat; //clamped at ceiling
	logic [7:0] miss_q;
	logic [7:0] miss_nx;
	logic [8:0] miss_sum;
	logic score_chg; //score moved last edge
	logic dlg_pend; //dialogue waiting for the link
	logic [3:0] dlg_code;
	logic [7:0] peer_score; //peer tens and units
	logic [3:0] peer_dlg; //last peer dialogue
	logic wb_req, wr_req; //new bus access
	logic [15:0] rd_mux;
	link_pkg::link_word_u rx_word, tx_score, tx_dlg;

	////////////////////
	// tally
	////////////////////
	always_comb begin
		hit_cnt = '0;
		miss_cnt = '0;
		for (int i = 0; i < N_LANES; i++) begin
			hit_cnt = hit_cnt + CNT_W'(lane_hit[i]);
			miss_cnt = miss_cnt + CNT_W'(lane_miss[i]);
		end
		score_bin = 10'(score_q[11:8]) * 10'd100 + 10'(score_q[7:4]) * 10'd10
			+ 10'(score_q[3:0]) + 10'(hit_cnt);
		score_sat = (score_bin > 10'(game_pkg::SCORE_MAX)) ? 10'(game_pkg::SCORE_MAX) : score_bin;
		score_nx = {4'(score_sat / 10'd100), 4'((score_sat / 10'd10) % 10'd10),
			4'(score_sat % 10'd10)}; //back to bcd
		miss_sum = 9'(miss_q) + 9'(miss_cnt);
		miss_nx = (miss_sum > 9'(game_pkg::MISS_MAX)) ? 8'(game_pkg::MISS_MAX) : miss_sum[7:0];
	end

	assign wb_req = wb_cyc & wb_stb & ~wb_ack;
	assign wr_req = wb_req & wb_we;
	assign rx_word = link_in;

	always_comb begin
		case (wb_adr)
			game_pkg::REG_CTRL: rd_mux = 16'(lane_en);
			game_pkg::REG_SCORE: rd_mux = {4'h0, score_q};
			game_pkg::REG_MISS: rd_mux = {8'h00, miss_q};
			game_pkg::REG_PEER: rd_mux = {4'h0, peer_dlg, peer_score};
			default: rd_mux = '0;
		endcase
		tx_score.score.kind = link_pkg::LINK_KIND_SCORE;
		tx_score.score.payload = score_q[7:0]; //tens and units only
		tx_dlg.dlg.kind = link_pkg::LINK_KIND_DLG;
		tx_dlg.dlg.code = dlg_code;
		tx_dlg.dlg.unused = '0;
	end

	////////////////////
	// control state
	////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			lane_en <= '0;
			round_start <= 1'b0;
			score_q <= '0;
			miss_q <= '0;
			score_chg <= 1'b0;
			dlg_pend <= 1'b0;
			peer_score <= '0;
			peer_dlg <= '0;
			link_out_valid <= 1'b0;
		end else begin
			wb_ack <= wb_req;
			round_start <= wr_req && wb_adr == game_pkg::REG_CTRL && wb_dat_w[15];
			if (wr_req && wb_adr == game_pkg::REG_CTRL)
				lane_en <= wb_dat_w[N_LANES-1:0];
			if (wr_req && wb_adr == game_pkg::REG_SCORE) begin
				score_q <= '0; //host clear beats tally
				miss_q <= '0;
				score_chg <= 1'b0;
			end else begin
				score_q <= score_nx;
				miss_q <= miss_nx;
				score_chg <= score_nx != score_q;
			end
			if (link_in_valid) begin
				if (rx_word.score.kind == link_pkg::LINK_KIND_SCORE)
					peer_score <= rx_word.score.payload;
				else
					peer_dlg <= rx_word.dlg.code;
			end
			link_out_valid <= score_chg | dlg_pend; //score first, dialogue waits
			if (wr_req && wb_adr == game_pkg::REG_PEER)
				dlg_pend <= 1'b1;
			else if (!score_chg)
				dlg_pend <= 1'b0; //went out this edge
		end
	end

	always_ff @(posedge clk) begin
		if (wb_req)
			wb_dat_r <= rd_mux;
		if (wr_req && wb_adr == game_pkg::REG_PEER)
			dlg_code <= wb_dat_w[3:0];
		link_out <= score_chg ? tx_score : tx_dlg;
	end

endmodule

`default_nettype wire

/* logic/game_top.sv */
`timescale 1ns/1ns
`default_nettype none

module game_top #(
	parameter int N_LANES = 4 //game lanes, 1 to 15
) (
	input wire clk, //system clock
	input wire rst, //sync reset, active high
	input wire [game_pkg::KEY_W-1:0] key, //keypad key code
	input wire pressed, //keypad press level
	input wire wb_cyc, //wishbone cycle
	input wire wb_stb, //wishbone strobe
	input wire wb_we, //wishbone write enable
	input wire [1:0] wb_adr, //register select
	input wire [15:0] wb_dat_w, //host write data
	output logic [15:0] wb_dat_r, //host read data
	output logic wb_ack, //wishbone ack
	input wire [link_pkg::LINK_W-1:0] link_in, //word from peer board
	input wire link_in_valid, //peer word strobe
	output logic [link_pkg::LINK_W-1:0] link_out, //word to peer board
	output logic link_out_valid //outgoing word strobe
);

	localparam int KW = game_pkg::KEY_W;

	logic [N_LANES-1:0] lane_en; //host lane mask
	logic round_start;
	logic load;
	logic [N_LANES*KW-1:0] targets;
	logic [N_LANES-1:0] arm;
	logic key_evt;
	logic [KW-1:0] key_code;
	logic [N_LANES-1:0] lane_hit; //also watched by assertions
	logic [N_LANES-1:0] lane_miss;

	round_dispatch #(
		.N_LANES(N_LANES)
	) dispatch_inst (
		.clk(clk),
		.rst(rst),
		.key(key), //raw key (I)
		.pressed(pressed), //press level (I)
		.lane_en(lane_en), //mask at start (I)
		.round_start(round_start), //from host regs (I)
		.load(load), //(O)
		.targets(targets), //(O)
		.arm(arm), //(O)
		.key_evt(key_evt), //(O)
		.key_code(key_code) //(O)
	);

	////////////////////
	// lanes
	////////////////////
	for (genvar i = 0; i < N_LANES; i++) begin : g_lane
		game_lane lane_inst (
			.clk(clk),
			.rst(rst),
			.load(load),
			.arm(arm[i]),
			.target(targets[i*KW +: KW]), //own slice
			.key_evt(key_evt),
			.key_code(key_code),
			.hit(lane_hit[i]),
			.miss(lane_miss[i])
		);
	end

	score_regs #(
		.N_LANES(N_LANES)
	) score_inst (
		.clk(clk),
		.rst(rst),
		.lane_hit(lane_hit), //(I)
		.lane_miss(lane_miss), //(I)
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.lane_en(lane_en), //(O)
		.round_start(round_start), //(O)
		.link_in(link_in),
		.link_in_valid(link_in_valid),
		.link_out(link_out),
		.link_out_valid(link_out_valid)
	);

endmodule

`default_nettype wire

/* test/game_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module game_sva #(
	parameter int N_LANES = 4 //lanes in the bound top
) (
	input wire clk,
	input wire rst,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_ack,
	input wire [N_LANES-1:0] lane_hit,
	input wire [N_LANES-1:0] lane_miss,
	input wire link_out_valid
);

	int assert_errs = 0; //failed assertions so far

	////////////////////
	// wishbone
	////////////////////
	ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb)) //ack answers a live strobe
		else begin
			$error("wb_ack rose without cyc and stb");
			assert_errs++;
		end

	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack held for two cycles");
			assert_errs++;
		end

	////////////////////
	// lanes and link
	////////////////////
	lane_grade_once: assert property (@(posedge clk) disable iff (rst)
		!(|(lane_hit & lane_miss))) //a lane grades one way only
		else begin
			$error("lane raised hit and miss together");
			assert_errs++;
		end

	link_quiet_reset: assert property (@(posedge clk)
		$past(rst) |-> !link_out_valid)
		else begin
			$error("link_out_valid high right after reset");
			assert_errs++;
		end

endmodule

bind game_top game_sva #(
	.N_LANES(N_LANES)
) game_sva_inst (
	.clk(clk),
	.rst(rst),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.lane_hit(lane_hit),
	.lane_miss(lane_miss),
	.link_out_valid(link_out_valid)
);

`default_nettype wire

/* test/game_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module game_tb;

	localparam int N_LANES = 4;
	localparam int KW = game_pkg::KEY_W;
	localparam int N_ROUNDS = 1300; //rounds over all tests, upper bound
	localparam int PRESSES = 4; //presses per round, upper bound
	localparam int WD_CYCLES = N_ROUNDS * PRESSES * 12 + 500;
	localparam int SAT_ROUNDS = 1100; //enough hits to pass 999

	logic clk;
	logic rst;
	logic [KW-1:0] key;
	logic pressed;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [15:0] wb_dat_w;
	wire [15:0] wb_dat_r;
	wire wb_ack;
	logic [link_pkg::LINK_W-1:0] link_in;
	logic link_in_valid;
	wire [link_pkg::LINK_W-1:0] link_out;
	wire link_out_valid;

	logic [31:0] rng; //stimulus lfsr
	logic [15:0] m_lfsr; //model of the target lfsr
	logic [KW-1:0] m_target [N_LANES];
	logic [N_LANES-1:0] m_armed;
	int m_score; //binary, model side
	int m_miss;
	logic [7:0] m_peer_score;
	logic [3:0] m_peer_dlg;
	logic [link_pkg::LINK_W-1:0] exp_link [$]; //words the model expects
	logic [link_pkg::LINK_W-1:0] got_link [$]; //words seen on link_out
	string test_name;
	int test_errs;
	int n_pass;
	int n_fail;

	game_top #(
		.N_LANES(N_LANES)
	) game_top_inst (
		.clk(clk),
		.rst(rst),
		.key(key),
		.pressed(pressed),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.link_in(link_in),
		.link_in_valid(link_in_valid),
		.link_out(link_out),
		.link_out_valid(link_out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; //40 ns period
	end

	initial begin
		#(WD_CYCLES * 40);
		$display("watchdog expired before the tests finished");
		$display("Test failures found");
		$finish;
	end

	always @(negedge clk) begin
		if (!rst && link_out_valid)
			got_link.push_back(link_out); //stable half a cycle in
	end

	////////////////////
	// helpers
	////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0); //galois shift
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			rng = lfsr_step(rng); //one step per bit
			v = (v << 1) | int'(rng[0]);
		end
		return v;
	endfunction

	function automatic logic [11:0] to_bcd(input int s);
		return {4'(s / 100), 4'((s / 10) % 10), 4'(s % 10)};
	endfunction

	function automatic int from_bcd(input logic [15:0] d);
		return int'(d[11:8]) * 100 + int'(d[7:4]) * 10 + int'(d[3:0]);
	endfunction

	function automatic logic [KW-1:0] miss_key();
		logic [KW-1:0] k;
		logic clash;
		k = '0;
		for (int v = 0; v < 16; v++) begin
			clash = 1'b0;
			for (int i = 0; i < N_LANES; i++)
				clash |= (m_target[i] == 4'(v)); //some lane wants v
			if (!clash)
				k = 4'(v);
		end
		return k;
	endfunction

	task automatic check_eq(input string what, input int exp, input int act);
		if (exp != act) begin
			$display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_ack && n < 20);
		if (!wb_ack) begin
			$display("%s: no wishbone ack within 20 cycles", test_name);
			test_errs++;
		end
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [15:0] dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = dat;
		wait_ack(); //write lands on the ack edge
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [15:0] dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		wait_ack();
		dat = wb_dat_r; //valid while ack high
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	////////////////////
	// stimulus with model
	////////////////////
	task automatic start_round(input logic [N_LANES-1:0] mask);
		wb_write(game_pkg::REG_CTRL, 16'h8000 | 16'(mask));
		for (int i = 0; i < N_LANES; i++) begin
			m_lfsr = {1'b0, m_lfsr[15:1]} ^ (m_lfsr[0] ? game_pkg::LANE_LFSR_TAPS : 16'h0);
			m_target[i] = m_lfsr[KW-1:0]; //low bits after step i+1
		end
		m_armed = mask;
		repeat (2) @(negedge clk); //lanes loaded
	endtask

	task automatic press(input logic [KW-1:0] k);
		int hits;
		int misses;
		logic [11:0] bcd;
		hits = 0;
		misses = 0;
		key = k;
		pressed = 1'b1;
		@(negedge clk);
		pressed = 1'b0;
		@(negedge clk);
		for (int i = 0; i < N_LANES; i++) begin
			if (m_armed[i]) begin
				if (m_target[i] == k)
					hits++;
				else
					misses++;
				m_armed[i] = 1'b0; //graded once
			end
		end
		if (hits > 0 && m_score < game_pkg::SCORE_MAX) begin
			m_score = (m_score + hits > game_pkg::SCORE_MAX) ? game_pkg::SCORE_MAX : m_score + hits;
			bcd = to_bcd(m_score);
			exp_link.push_back({link_pkg::LINK_KIND_SCORE, bcd[7:0]});
		end
		m_miss = (m_miss + misses > game_pkg::MISS_MAX) ? game_pkg::MISS_MAX : m_miss + misses;
	endtask

	task automatic check_counts();
		logic [15:0] d;
		repeat (6) @(negedge clk); //pipeline drains
		wb_read(game_pkg::REG_SCORE, d);
		check_eq("score", to_bcd(m_score), d);
		wb_read(game_pkg::REG_MISS, d);
		check_eq("misses", m_miss, d);
	endtask

	task automatic check_link();
		repeat (6) @(negedge clk);
		while (exp_link.size() > 0) begin
			if (got_link.size() == 0) begin
				$display("%s: link word %0h was never sent", test_name, exp_link[0]);
				test_errs++;
				exp_link.delete();
			end else begin
				check_eq("link word", exp_link.pop_front(), got_link.pop_front());
			end
		end
		if (got_link.size() > 0) begin
			$display("%s: %0d link words sent without cause", test_name, got_link.size());
			test_errs++;
			got_link.delete();
		end
	endtask

	task automatic finish_test();
		check_link();
		check_counts();
		if (test_errs == 0) begin
			$display("test %s ok", test_name);
			n_pass++;
		end else begin
			$display("test %s: %0d errors", test_name, test_errs);
			n_fail++;
		end
		test_errs = 0;
	endtask

	////////////////////
	// tests
	////////////////////
	initial begin
		logic [15:0] d;
		logic [N_LANES-1:0] mask;
		logic [KW-1:0] k;
		logic [7:0] pbyte;
		int sc0;
		int ms0;
		int ms1;
		rng = 32'h2ebb;
		key = '0;
		pressed = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		link_in = '0;
		link_in_valid = 1'b0;
		m_lfsr = game_pkg::LANE_LFSR_SEED;
		m_armed = '0;
		m_score = 0;
		m_miss = 0;
		m_peer_score = '0;
		m_peer_dlg = '0;
		test_errs = 0;
		n_pass = 0;
		n_fail = 0;
		rst = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_name = "reset_values";
		for (int a = 0; a < 4; a++) begin
			wb_read(2'(a), d);
			check_eq($sformatf("reg %0d", a), 0, d);
		end
		finish_test(); //no link word may show up yet

		test_name = "random_round";
		for (int r = 0; r < 20; r++) begin
			start_round('1);
			for (int p = 0; p < 3; p++) begin
				if (rand_bits(1))
					k = m_target[rand_bits(2)]; //sure hit, maybe shared
				else
					k = 4'(rand_bits(KW));
				press(k);
			end
		end
		finish_test();

		test_name = "graded_once";
		start_round('1);
		sc0 = m_score;
		ms0 = m_miss;
		press(miss_key()); //every lane misses
		for (int i = 0; i < N_LANES; i++)
			press(m_target[i]); //too late for a hit
		repeat (6) @(negedge clk);
		wb_read(game_pkg::REG_SCORE, d);
		check_eq("score after late hits", to_bcd(sc0), d);
		wb_read(game_pkg::REG_MISS, d);
		check_eq("one miss per lane", ms0 + N_LANES, d);
		finish_test();

		test_name = "disabled_lanes";
		for (int r = 0; r < 10; r++) begin
			mask = N_LANES'(rand_bits(N_LANES));
			mask[rand_bits(2)] = 1'b0; //at least one lane sits out
			sc0 = m_score;
			ms0 = m_miss;
			start_round(mask);
			wb_read(game_pkg::REG_CTRL, d);
			check_eq("lane mask", mask, d);
			for (int i = 0; i < N_LANES; i++)
				press(m_target[i]);
			repeat (6) @(negedge clk);
			wb_read(game_pkg::REG_MISS, d);
			ms1 = d;
			wb_read(game_pkg::REG_SCORE, d);
			check_eq("graded lanes", sc0 + ms0 + $countones(mask), from_bcd(d) + ms1);
		end
		finish_test();

		test_name = "link";
		for (int r = 0; r < 8; r++) begin
			start_round('1);
			press(m_target[rand_bits(2)]); //score word
			repeat (6) @(negedge clk);
			k = 4'(rand_bits(4));
			wb_write(game_pkg::REG_PEER, 16'(k));
			exp_link.push_back({link_pkg::LINK_KIND_DLG, k, 4'h0});
			pbyte = {4'(rand_bits(4) % 10), 4'(rand_bits(4) % 10)};
			link_in = {link_pkg::LINK_KIND_SCORE, pbyte};
			link_in_valid = 1'b1;
			@(negedge clk);
			k = 4'(rand_bits(4));
			link_in = {link_pkg::LINK_KIND_DLG, k, 4'h0};
			@(negedge clk);
			link_in_valid = 1'b0;
			m_peer_score = pbyte;
			m_peer_dlg = k;
			wb_read(game_pkg::REG_PEER, d);
			check_eq("peer fields", {4'h0, m_peer_dlg, m_peer_score}, d);
		end
		finish_test();

		test_name = "saturation";
		for (int r = 0; r < SAT_ROUNDS; r++) begin
			start_round('1);
			press(m_target[rand_bits(2)]);
			press(4'(rand_bits(KW))); //all lanes done already
			if (r % 100 == 99)
				check_counts();
		end
		check_link();
		wb_read(game_pkg::REG_SCORE, d);
		check_eq("score at ceiling", to_bcd(game_pkg::SCORE_MAX), d);
		check_counts();
		wb_write(game_pkg::REG_SCORE, 16'h0000); //clear score and misses
		m_score = 0;
		m_miss = 0;
		finish_test();

		$display("tests passed %0d, failed %0d, assertion failures %0d", n_pass, n_fail,
			game_top_inst.game_sva_inst.assert_errs);
		if (n_fail == 0 && game_top_inst.game_sva_inst.assert_errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
logic/game_pkg.sv
logic/link_pkg.sv
logic/round_dispatch.sv
logic/game_lane.sv
logic/score_regs.sv
logic/game_top.sv
test/game_sva.sv
test/game_tb.sv
